// ==== mipsPkg.sv ====
package mipsPkg;

	// ========================================================================
	// instruction encodings
	// ========================================================================

	// primary opcodes, instr[31:26]
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// function codes under opRtype, instr[5:0]
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnSlt  = 6'h2a;

	// ========================================================================
	// control and stage payloads
	// ========================================================================

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluLui
	} aluOpT;

	// all zeros is a bubble
	typedef struct packed {
		logic valid;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrcImm;
		logic regDst;     // 1 selects rd, 0 selects rt
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [4:0] dst;
	} exMemT;

	typedef struct packed {
		ctrlT ctrl;
		logic [31:0] aluResult;
		logic [4:0] dst;
	} memWbT;

endpackage

// ==== pipeReg.sv ====
`timescale 1ns/100ps

module pipeReg #(
	parameter type payloadT = logic [31:0]
) (
	input logic clk,
	input logic arstN,
	input logic en,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// zero payload means invalid control, so reset and flush both insert a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (flush) begin
			// flush wins over a held stage
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/100ps

module instrDecode import mipsPkg::*; (
	input ifIdT ifId,
	input logic [31:0] rsVal,
	input logic [31:0] rtVal,
	input logic [31:0] fwdValue,
	input logic fwdA,
	input logic fwdB,
	output idExT idEx,
	output logic pcSel,
	output logic [31:0] target
);

	logic [5:0] op;
	logic [5:0] funct;
	logic [15:0] imm16;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] signImm;
	logic isBeq;
	logic isBne;
	logic isJ;

	// instruction fields
	assign op = ifId.instr[31:26];
	assign funct = ifId.instr[5:0];
	assign imm16 = ifId.instr[15:0];
	assign signImm = {{16{imm16[15]}}, imm16};

	// operands after the memory-stage bypass
	assign opA = fwdA ? fwdValue : rsVal;
	assign opB = fwdB ? fwdValue : rtVal;

	// ========================================================================
	// control decode
	// ========================================================================
	always_comb begin
		idEx = '0;
		idEx.rsVal = opA;
		idEx.rtVal = opB;
		// ori zero-extends, everything else sign-extends
		idEx.imm = (op == opOri) ? {16'h0, imm16} : signImm;
		idEx.rs = ifId.instr[25:21];
		idEx.rt = ifId.instr[20:16];
		idEx.rd = ifId.instr[15:11];
		idEx.shamt = ifId.instr[10:6];
		case (op)
			opRtype: begin
				idEx.ctrl.valid = 1'b1;
				idEx.ctrl.regWrite = 1'b1;
				idEx.ctrl.regDst = 1'b1;
				case (funct)
					fnAddu: idEx.ctrl.aluOp = aluAdd;
					fnSubu: idEx.ctrl.aluOp = aluSub;
					fnAnd: idEx.ctrl.aluOp = aluAnd;
					fnOr: idEx.ctrl.aluOp = aluOr;
					fnXor: idEx.ctrl.aluOp = aluXor;
					fnSlt: idEx.ctrl.aluOp = aluSlt;
					fnSll: idEx.ctrl.aluOp = aluSll;
					fnSrl: idEx.ctrl.aluOp = aluSrl;
					// unknown funct becomes a bubble
					default: idEx.ctrl = '0;
				endcase
			end
			opAddiu, opOri, opLui: begin
				idEx.ctrl.valid = 1'b1;
				idEx.ctrl.regWrite = 1'b1;
				idEx.ctrl.aluSrcImm = 1'b1;
				idEx.ctrl.aluOp = (op == opOri) ? aluOr : (op == opLui) ? aluLui : aluAdd;
			end
			opLw: begin
				idEx.ctrl.valid = 1'b1;
				idEx.ctrl.regWrite = 1'b1;
				idEx.ctrl.memToReg = 1'b1;
				idEx.ctrl.aluSrcImm = 1'b1;
				idEx.ctrl.aluOp = aluAdd;
			end
			opSw: begin
				idEx.ctrl.valid = 1'b1;
				idEx.ctrl.memWrite = 1'b1;
				idEx.ctrl.aluSrcImm = 1'b1;
				idEx.ctrl.aluOp = aluAdd;
			end
			// branches and jumps finish here, nothing left for later stages
			opBeq, opBne, opJ: idEx.ctrl.valid = 1'b1;
			default: idEx.ctrl = '0;
		endcase
	end

	// ========================================================================
	// branch resolution
	// ========================================================================
	assign isBeq = (op == opBeq);
	assign isBne = (op == opBne);
	assign isJ = (op == opJ);

	assign pcSel = (isBeq && (opA == opB)) || (isBne && (opA != opB)) || isJ;

	// jump keeps the region bits of the delay slot address
	assign target = isJ ? {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00}
		: ifId.pcPlus4 + {signImm[29:0], 2'b00};

	// a taken redirect lands on a word address
	always_comb begin
		if (pcSel) begin
			assert (target[1:0] == 2'b00);
		end
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic arstN,
	input logic we,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [0:31];

	// falling-edge write, decode sees writeback data in the same cycle
	always_ff @(negedge clk) begin
		if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// $zero is hardwired
	assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

	// writeback must never present an X destination
	assert property (@(negedge clk) disable iff (!arstN) we |-> !$isunknown(wa));

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit import mipsPkg::*; (
	// decode
	input logic [4:0] rsD,
	input logic [4:0] rtD,
	input logic branchD,
	// execute
	input ctrlT exCtrl,
	input logic [4:0] exRs,
	input logic [4:0] exRt,
	input logic [4:0] exDst,
	// memory
	input ctrlT memCtrl,
	input logic [4:0] memDst,
	// writeback
	input logic wbRegWrite,
	input logic [4:0] wbDst,
	output logic stall,
	output logic flushEx,
	output logic fwdDecA,
	output logic fwdDecB,
	output logic [1:0] fwdExA,
	output logic [1:0] fwdExB
);

	logic exHitsD;
	logic memLoadHitsD;
	logic lwStall;
	logic branchStall;

	// 2'b10 memory result, 2'b01 writeback result, 2'b00 register value
	function automatic logic [1:0] exSel(input logic [4:0] src);
		if (src != 5'd0 && memCtrl.regWrite && memDst == src) begin
			return 2'b10;
		end else if (src != 5'd0 && wbRegWrite && wbDst == src) begin
			return 2'b01;
		end
		return 2'b00;
	endfunction

	// ========================================================================
	// forwarding
	// ========================================================================
	// decode bypass only carries alu results, loads are stalled instead
	assign fwdDecA = (rsD != 5'd0) && memCtrl.regWrite && !memCtrl.memToReg && (memDst == rsD);
	assign fwdDecB = (rtD != 5'd0) && memCtrl.regWrite && !memCtrl.memToReg && (memDst == rtD);

	assign fwdExA = exSel(exRs);
	assign fwdExB = exSel(exRt);

	// ========================================================================
	// stalls
	// ========================================================================
	assign exHitsD = exCtrl.regWrite && (exDst != 5'd0) && (exDst == rsD || exDst == rtD);
	assign memLoadHitsD = memCtrl.memToReg && (memDst != 5'd0)
		&& (memDst == rsD || memDst == rtD);

	// load in execute, consumer in decode
	assign lwStall = exCtrl.memToReg && exHitsD;
	// branch compares in decode, needs the result one stage earlier
	assign branchStall = branchD && (exHitsD || memLoadHitsD);

	assign stall = lwStall || branchStall;
	assign flushEx = stall;

	// every load seen by the hazard checks also writes a register
	always_comb begin
		assert (!exCtrl.memToReg || exCtrl.regWrite);
		assert (!memCtrl.memToReg || memCtrl.regWrite);
	end

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/100ps

module aluExecute import mipsPkg::*; (
	input idExT idEx,
	input logic [1:0] fwdA,
	input logic [1:0] fwdB,
	input logic [31:0] memResult,
	input logic [31:0] wbResult,
	output exMemT exMem
);

	logic [31:0] srcA;
	logic [31:0] fwdValB;
	logic [31:0] srcB;
	logic [31:0] result;

	// operand bypass, memory is younger so it wins
	always_comb begin
		case (fwdA)
			2'b10: srcA = memResult;
			2'b01: srcA = wbResult;
			default: srcA = idEx.rsVal;
		endcase
		case (fwdB)
			2'b10: fwdValB = memResult;
			2'b01: fwdValB = wbResult;
			default: fwdValB = idEx.rtVal;
		endcase
	end

	// immediate replaces rt for I-type
	assign srcB = idEx.ctrl.aluSrcImm ? idEx.imm : fwdValB;

	// ========================================================================
	// alu
	// ========================================================================
	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd: result = srcA + srcB;
			aluSub: result = srcA - srcB;
			aluAnd: result = srcA & srcB;
			aluOr: result = srcA | srcB;
			aluXor: result = srcA ^ srcB;
			aluSlt: result = {31'h0, $signed(srcA) < $signed(srcB)};
			// shifts act on rt by shamt
			aluSll: result = srcB << idEx.shamt;
			aluSrl: result = srcB >> idEx.shamt;
			aluLui: result = {srcB[15:0], 16'h0};
			default: result = 32'h0;
		endcase
	end

	assign exMem.ctrl = idEx.ctrl;
	assign exMem.aluResult = result;
	// store data is the bypassed rt, never the immediate
	assign exMem.storeData = fwdValB;
	assign exMem.dst = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

endmodule

// ==== writeBack.sv ====
`timescale 1ns/100ps

module writeBack import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input exMemT exMem,
	input logic [31:0] readData,
	output logic we,
	output logic [4:0] wa,
	output logic [31:0] wd,
	output logic retire,
	output logic [4:0] retireReg,
	output logic [31:0] retireData
);

	memWbT memWbD;
	memWbT memWbQ;
	logic [31:0] loadData;

	// drop store data on the way into writeback
	assign memWbD = '{ctrl: exMem.ctrl, aluResult: exMem.aluResult, dst: exMem.dst};

	pipeReg #(.payloadT(memWbT)) memWbReg (
		.clk(clk),
		.arstN(arstN),
		.en(1'b1),
		.flush(1'b0),
		.d(memWbD),
		.q(memWbQ)
	);

	// load data sampled alongside the stage register
	always_ff @(posedge clk) begin
		loadData <= readData;
	end

	// result select
	assign we = memWbQ.ctrl.valid && memWbQ.ctrl.regWrite;
	assign wa = memWbQ.dst;
	assign wd = memWbQ.ctrl.memToReg ? loadData : memWbQ.aluResult;

	// writes to $zero are architecturally invisible, no retire
	assign retire = we && (wa != 5'd0);
	assign retireReg = wa;
	assign retireData = wd;

endmodule

// ==== mipsCore.sv ====
`timescale 1ns/100ps

module mipsCore import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input logic clk,
	input logic arstN,
	// instruction port
	output logic [31:0] instrAddr,
	input logic [31:0] instr,
	// data port
	output logic [31:0] dataAddr,
	output logic [31:0] writeData,
	output logic memWrite,
	input logic [31:0] readData,
	// retire trace
	output logic retire,
	output logic [4:0] retireReg,
	output logic [31:0] retireData
);

	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic pcSel;
	logic [31:0] target;
	logic stall;
	logic flushEx;
	logic fwdDecA;
	logic fwdDecB;
	logic [1:0] fwdExA;
	logic [1:0] fwdExB;
	logic branchD;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic rfWe;
	logic [4:0] rfWa;
	logic [31:0] rfWd;
	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;

	// ========================================================================
	// fetch
	// ========================================================================
	assign pcPlus4 = pc + 32'd4;

	// redirect lands one edge after the branch decodes, delay slot already in IF
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
		end else if (!stall) begin
			pc <= pcSel ? target : pcPlus4;
		end
	end

	assign instrAddr = pc;
	assign ifIdD = '{instr: instr, pcPlus4: pcPlus4};

	pipeReg #(.payloadT(ifIdT)) ifIdReg (
		.clk(clk), .arstN(arstN), .en(!stall), .flush(1'b0), .d(ifIdD), .q(ifIdQ)
	);

	// ========================================================================
	// decode
	// ========================================================================
	regFile rf (
		.clk(clk), .arstN(arstN), .we(rfWe),
		.ra1(ifIdQ.instr[25:21]), .ra2(ifIdQ.instr[20:16]), .wa(rfWa), .wd(rfWd),
		.rd1(rsVal), .rd2(rtVal)
	);

	instrDecode dec (
		.ifId(ifIdQ), .rsVal(rsVal), .rtVal(rtVal), .fwdValue(exMemQ.aluResult),
		.fwdA(fwdDecA), .fwdB(fwdDecB), .idEx(idExD), .pcSel(pcSel), .target(target)
	);

	// only conditional branches read registers in decode
	assign branchD = (ifIdQ.instr[31:26] == opBeq) || (ifIdQ.instr[31:26] == opBne);

	hazardUnit hz (
		.rsD(idExD.rs), .rtD(idExD.rt), .branchD(branchD),
		.exCtrl(idExQ.ctrl), .exRs(idExQ.rs), .exRt(idExQ.rt), .exDst(exMemD.dst),
		.memCtrl(exMemQ.ctrl), .memDst(exMemQ.dst),
		.wbRegWrite(rfWe), .wbDst(rfWa),
		.stall(stall), .flushEx(flushEx), .fwdDecA(fwdDecA), .fwdDecB(fwdDecB),
		.fwdExA(fwdExA), .fwdExB(fwdExB)
	);

	pipeReg #(.payloadT(idExT)) idExReg (
		.clk(clk), .arstN(arstN), .en(1'b1), .flush(flushEx), .d(idExD), .q(idExQ)
	);

	// ========================================================================
	// execute, memory, writeback
	// ========================================================================
	aluExecute ex (
		.idEx(idExQ), .fwdA(fwdExA), .fwdB(fwdExB),
		.memResult(exMemQ.aluResult), .wbResult(rfWd), .exMem(exMemD)
	);

	pipeReg #(.payloadT(exMemT)) exMemReg (
		.clk(clk), .arstN(arstN), .en(1'b1), .flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	// data memory answers combinationally in this stage
	assign dataAddr = exMemQ.aluResult;
	assign writeData = exMemQ.storeData;
	assign memWrite = exMemQ.ctrl.memWrite;

	writeBack wb (
		.clk(clk), .arstN(arstN), .exMem(exMemQ), .readData(readData),
		.we(rfWe), .wa(rfWa), .wd(rfWd),
		.retire(retire), .retireReg(retireReg), .retireData(retireData)
	);

	// a stall cycle leaves a bubble in execute
	assert property (@(posedge clk) disable iff (!arstN) stall |=> !idExQ.ctrl.valid);

endmodule

// ==== tb_mipsCore.sv ====
`timescale 1ns/100ps

module tb_mipsCore import mipsPkg::*; ();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 8;
	localparam int progLen = 200;
	// registers 1..8 plus $zero form the operand pool
	localparam int poolRegs = 8;
	// worst case a few stall cycles per instruction, plus drain margin
	localparam int timeoutCycles = progLen * 4 + resetCycles + 100;

	typedef struct packed {
		logic [4:0] dst;
		logic [31:0] data;
	} retireT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} storeT;

	logic clk = 1'b0;
	logic arstN = 1'b1;
	logic [31:0] instr = 32'h0;
	logic [31:0] readData = 32'h0;
	logic [31:0] instrAddr;
	logic [31:0] dataAddr;
	logic [31:0] writeData;
	logic memWrite;
	logic retire;
	logic [4:0] retireReg;
	logic [31:0] retireData;

	int seed = 93;
	logic done = 1'b0;
	int retireErrors = 0;
	int storeErrors = 0;
	int retireIdx = 0;
	int storeIdx = 0;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:63];
	logic branchAt [0:255];
	logic targetAt [0:255];
	logic [31:0] modelRegs [0:31];
	logic [31:0] modelMem [0:63];
	retireT expRetire [$];
	storeT expStore [$];

	mipsCore #(.resetPc(32'h0000_0000)) uut (
		.clk(clk), .arstN(arstN),
		.instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite), .readData(readData),
		.retire(retire), .retireReg(retireReg), .retireData(retireData)
	);

	initial begin
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// ========================================================================
	// helpers
	// ========================================================================
	function automatic int randBelow(input int n);
		return {$random(seed)} % n;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'(randBelow(poolRegs + 1));
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {opRtype, rs, rt, rd, sh, fn};
	endfunction

	// initial data memory contents, mixed from every address bit
	function automatic logic [31:0] fillWord(input logic [5:0] w);
		return ({w, 2'b00} * 32'h9e37_79b9) ^ {26'h2a5_f3c1, w};
	endfunction

	// ========================================================================
	// random program generator
	// ========================================================================
	task automatic genProgram();
		int i;
		int k;
		int t;
		logic canBranch;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		for (i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
			branchAt[i] = 1'b0;
			targetAt[i] = 1'b0;
		end
		// prologue, every pool register gets a known value
		for (i = 1; i <= poolRegs; i++) begin
			imem[i - 1] = iWord(opAddiu, 5'd0, 5'(i), 16'(randBelow(65536)));
		end
		for (i = poolRegs; i < progLen; i++) begin
			k = randBelow(16);
			rs = pickReg();
			rt = pickReg();
			rd = pickReg();
			imm = 16'(randBelow(65536));
			// no branch in a delay slot, no slot on a target
			canBranch = !branchAt[i - 1] && !targetAt[i + 1] && (i + 2 < progLen);
			if (k >= 13 && canBranch) begin
				t = i + 2 + randBelow(8);
				if (t > progLen - 1) begin
					t = progLen - 1;
				end
				branchAt[i] = 1'b1;
				targetAt[t] = 1'b1;
				// equal operands now and then, so beq gets taken
				if (randBelow(4) == 0) begin
					rt = rs;
				end
				case (k)
					13: imem[i] = iWord(opBeq, rs, rt, 16'(t - i - 1));
					14: imem[i] = iWord(opBne, rs, rt, 16'(t - i - 1));
					default: imem[i] = {opJ, 26'(t)};
				endcase
			end else if (k >= 11) begin
				imem[i] = iWord(opSw, 5'd0, rt, 16'(randBelow(64) * 4));
			end else if (k >= 9) begin
				imem[i] = iWord(opLw, 5'd0, rt, 16'(randBelow(64) * 4));
			end else if (k >= 6) begin
				case (randBelow(3))
					0: imem[i] = iWord(opAddiu, rs, rt, imm);
					1: imem[i] = iWord(opOri, rs, rt, imm);
					default: imem[i] = iWord(opLui, 5'd0, rt, imm);
				endcase
			end else begin
				case (randBelow(8))
					0: imem[i] = rWord(rs, rt, rd, 5'd0, fnAddu);
					1: imem[i] = rWord(rs, rt, rd, 5'd0, fnSubu);
					2: imem[i] = rWord(rs, rt, rd, 5'd0, fnAnd);
					3: imem[i] = rWord(rs, rt, rd, 5'd0, fnOr);
					4: imem[i] = rWord(rs, rt, rd, 5'd0, fnXor);
					5: imem[i] = rWord(rs, rt, rd, 5'd0, fnSlt);
					6: imem[i] = rWord(5'd0, rt, rd, 5'(randBelow(32)), fnSll);
					default: imem[i] = rWord(5'd0, rt, rd, 5'(randBelow(32)), fnSrl);
				endcase
			end
		end
	endtask

	// ========================================================================
	// ISA reference model, sequential with one delay slot
	// ========================================================================
	task automatic recordWrite(input logic [4:0] dst, input logic [31:0] val);
		retireT e;
		// $zero writes vanish from the trace
		if (dst != 5'd0) begin
			modelRegs[dst] = val;
			e.dst = dst;
			e.data = val;
			expRetire.push_back(e);
		end
	endtask

	task automatic runModel();
		int pc;
		int npc;
		int newNpc;
		int w;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		storeT st;
		for (w = 0; w < 32; w++) begin
			modelRegs[w] = 32'h0;
		end
		for (w = 0; w < 64; w++) begin
			modelMem[w] = fillWord(6'(w));
		end
		pc = 0;
		npc = 1;
		while (pc < progLen) begin
			ins = imem[pc];
			a = modelRegs[ins[25:21]];
			b = modelRegs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = a + simm;
			newNpc = npc + 1;
			case (ins[31:26])
				opRtype: begin
					case (ins[5:0])
						fnAddu: recordWrite(ins[15:11], a + b);
						fnSubu: recordWrite(ins[15:11], a - b);
						fnAnd: recordWrite(ins[15:11], a & b);
						fnOr: recordWrite(ins[15:11], a | b);
						fnXor: recordWrite(ins[15:11], a ^ b);
						fnSlt: recordWrite(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						fnSll: recordWrite(ins[15:11], b << ins[10:6]);
						fnSrl: recordWrite(ins[15:11], b >> ins[10:6]);
						default: ;
					endcase
				end
				opAddiu: recordWrite(ins[20:16], addr);
				opOri: recordWrite(ins[20:16], a | {16'h0, ins[15:0]});
				opLui: recordWrite(ins[20:16], {ins[15:0], 16'h0});
				opLw: recordWrite(ins[20:16], modelMem[addr[7:2]]);
				opSw: begin
					modelMem[addr[7:2]] = b;
					st.addr = addr;
					st.data = b;
					expStore.push_back(st);
				end
				// target index relative to the delay slot
				opBeq: begin
					if (a == b) begin
						newNpc = pc + 1 + int'($signed(simm));
					end
				end
				opBne: begin
					if (a != b) begin
						newNpc = pc + 1 + int'($signed(simm));
					end
				end
				opJ: newNpc = int'(ins[25:0]);
				default: ;
			endcase
			pc = npc;
			npc = newNpc;
		end
	endtask

	// ========================================================================
	// checks
	// ========================================================================
	task automatic checkRetire(input logic [4:0] gotReg, input logic [31:0] gotData);
		retireT e;
		if (retireIdx >= expRetire.size()) begin
			$display("unexpected retirement of r%0d after the model trace ended", gotReg);
			retireErrors++;
		end else begin
			e = expRetire[retireIdx];
			if (gotReg !== e.dst || gotData !== e.data) begin
				$display("Fail at %0t: retire #%0d r%0d = %h, expected r%0d = %h",
					$time, retireIdx, gotReg, gotData, e.dst, e.data);
				retireErrors++;
			end
			retireIdx++;
		end
	endtask

	task automatic checkStore(input logic [31:0] gotAddr, input logic [31:0] gotData);
		storeT e;
		if (storeIdx >= expStore.size()) begin
			$display("unexpected store to address %h after the model trace ended", gotAddr);
			storeErrors++;
		end else begin
			e = expStore[storeIdx];
			if (gotAddr !== e.addr || gotData !== e.data) begin
				$display("Fail at %0t: store #%0d [%h] = %h, expected [%h] = %h",
					$time, storeIdx, gotAddr, gotData, e.addr, e.data);
				storeErrors++;
			end
			storeIdx++;
		end
	endtask

	// memories answer on the falling edge, outputs settled since the rising edge
	always @(negedge clk) begin
		if (!arstN) begin
			for (int w = 0; w < 64; w++) begin
				dmem[w] <= fillWord(6'(w));
			end
		end else begin
			if (memWrite) begin
				checkStore(dataAddr, writeData);
				dmem[dataAddr[7:2]] <= writeData;
			end
			if (retire) begin
				checkRetire(retireReg, retireData);
			end
		end
		// past the program the core sees nops
		instr <= (instrAddr < 32'd1024) ? imem[instrAddr[9:2]] : 32'h0;
		readData <= dmem[dataAddr[7:2]];
	end

	// ========================================================================
	// main sequence and watchdog
	// ========================================================================
	initial begin
		arstN = 1'b0;
		genProgram();
		runModel();
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		while (retireIdx < expRetire.size() || storeIdx < expStore.size()) begin
			@(posedge clk);
		end
		// extra cycles catch anything retiring past the trace
		repeat (20) @(posedge clk);
		done = 1'b1;
		$display("retire errors: %0d, store errors: %0d (%0d retirements, %0d stores)",
			retireErrors, storeErrors, retireIdx, storeIdx);
		if (retireErrors == 0 && storeErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		if (!done) begin
			$display("pipeline stopped retiring: %0d retirements and %0d stores still expected",
				expRetire.size() - retireIdx, expStore.size() - storeIdx);
			$display("Errors found");
			$finish;
		end
	end

endmodule

// ==== mipsCore.f ====
mipsPkg.sv
pipeReg.sv
instrDecode.sv
regFile.sv
hazardUnit.sv
aluExecute.sv
writeBack.sv
mipsCore.sv
tb_mipsCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mipsCore
FILELIST  := mipsCore.f
OBJDIR    := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJDIR)
